// ==== Bender.yml ====
package:
  name: gfx_demo

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/gfx_pkg.sv
      - verilog/gfx_test_pattern.sv
      - verilog/gfx_framebuffer.sv
      - verilog/vga_timing.sv
      - verilog/vga_scanout.sv
      - verilog/gfx_demo.sv
  - target: simulation
    files:
      - sim/gfx_demo_tb.sv

// ==== gfx_demo.f ====
+incdir+verilog
verilog/gfx_pkg.sv
verilog/gfx_test_pattern.sv
verilog/gfx_framebuffer.sv
verilog/vga_timing.sv
verilog/vga_scanout.sv
verilog/gfx_demo.sv
sim/gfx_demo_tb.sv

// ==== sim/gfx_demo_tb.sv ====
`timescale 1ns/1ns

`include "gfx_macros.svh"

module gfx_demo_tb import gfx_pkg::*;;

  localparam int N_TESTS = 5;

  logic                       clk;
  logic                       arst_n;
  logic [`GFX_COLOR_BITS-1:0] vga_red;
  logic [`GFX_COLOR_BITS-1:0] vga_grn;
  logic [`GFX_COLOR_BITS-1:0] vga_blu;
  logic                       vga_hsync;
  logic                       vga_vsync;

  rgb_t  pin_color;
  rgb_t  exp_color;
  string names [N_TESTS];
  int    errs [N_TESTS];
  int    checks [N_TESTS];

  // pin history counted in samples at the rising edge
  int   rel_cycles;
  logic hs_prev;
  logic vs_prev;
  int   hs_low_len;
  int   vs_low_len;
  int   hs_since_fall;
  int   vs_since_fall;
  logic hs_fall_seen;
  logic vs_fall_seen;
  int   vs_falls;
  logic hs_fell;
  logic hs_rose;
  logic vs_fell;
  logic vs_rose;

  // reference beam at the pin position of the next sample
  logic synced;
  int   mx;
  int   my;
  logic m_vis;
  int   hits [`GFX_FB_DEPTH];

  gfx_demo dut0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

  always #10 clk = ~clk;

  assign pin_color = {vga_red, vga_grn, vga_blu};
  assign hs_fell   = hs_prev && !vga_hsync;
  assign hs_rose   = !hs_prev && vga_hsync;
  assign vs_fell   = vs_prev && !vga_vsync;
  assign vs_rose   = !vs_prev && vga_vsync;
  assign m_vis     = synced && (mx < `GFX_H_VISIBLE) && (my < `GFX_V_VISIBLE);

  // red is x and grn is y with blu as x xor y
  always_comb begin
    exp_color.red = 4'(mx);
    exp_color.grn = 4'(my);
    exp_color.blu = 4'(mx ^ my);
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rel_cycles    <= 0;
      hs_prev       <= 1'b1;
      vs_prev       <= 1'b1;
      hs_low_len    <= 0;
      vs_low_len    <= 0;
      hs_since_fall <= 0;
      vs_since_fall <= 0;
      hs_fall_seen  <= 1'b0;
      vs_fall_seen  <= 1'b0;
      vs_falls      <= 0;
      synced        <= 1'b0;
      mx            <= 0;
      my            <= 0;
      for (int i = 0; i < `GFX_FB_DEPTH; i++) begin
        hits[i] <= 0;
      end
      for (int i = 0; i < N_TESTS; i++) begin
        checks[i] <= 0;
      end
    end else begin
      rel_cycles    <= rel_cycles + 1;
      hs_prev       <= vga_hsync;
      vs_prev       <= vga_vsync;
      hs_low_len    <= vga_hsync ? 0 : hs_low_len + 1;
      vs_low_len    <= vga_vsync ? 0 : vs_low_len + 1;
      hs_since_fall <= hs_fell ? 1 : hs_since_fall + 1;
      vs_since_fall <= vs_fell ? 1 : vs_since_fall + 1;
      if (hs_fell) begin
        hs_fall_seen <= 1'b1;
      end
      if (vs_fell) begin
        vs_fall_seen <= 1'b1;
        vs_falls     <= vs_falls + 1;
      end
      // the first vsync fall is pin position (0, 9) and the next sample is x=1
      if (!synced && vs_fell) begin
        synced <= 1'b1;
        mx     <= 1;
        my     <= `GFX_V_SYNC_START;
      end else if (synced) begin
        if (mx == `GFX_H_WHOLE_LINE - 1) begin
          mx <= 0;
          my <= (my == `GFX_V_WHOLE_FRAME - 1) ? 0 : my + 1;
        end else begin
          mx <= mx + 1;
        end
        if (m_vis) begin
          hits[my * `GFX_H_VISIBLE + mx] <= hits[my * `GFX_H_VISIBLE + mx] + 1;
        end
      end
      if (rel_cycles < `GFX_FB_DEPTH) checks[0] <= checks[0] + 1;
      if (hs_rose || (hs_fell && hs_fall_seen)) checks[1] <= checks[1] + 1;
      if (vs_rose || (vs_fell && vs_fall_seen)) checks[2] <= checks[2] + 1;
      if (m_vis) checks[3] <= checks[3] + 1;
      if (synced && !m_vis) checks[4] <= checks[4] + 1;
    end
  end

  // no frame can be complete before 128 pixel transfers
  a_reset_idle: assert property (@(posedge clk) disable iff (!arst_n)
      rel_cycles >= `GFX_FB_DEPTH || (vga_hsync && vga_vsync && pin_color == '0))
    else begin
      errs[0]++;
      $display("FAILED %s: expected hsync 1 vsync 1 colour 000, actual %0b %0b %03h",
               names[0], $sampled(vga_hsync), $sampled(vga_vsync), $sampled(pin_color));
    end

  a_hsync_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      !hs_rose || hs_low_len == `GFX_H_SYNC_PULSE)
    else begin
      errs[1]++;
      $display("FAILED %s: expected pulse %0d, actual %0d",
               names[1], `GFX_H_SYNC_PULSE, $sampled(hs_low_len));
    end

  a_hsync_period: assert property (@(posedge clk) disable iff (!arst_n)
      !(hs_fell && hs_fall_seen) || hs_since_fall == `GFX_H_WHOLE_LINE)
    else begin
      errs[1]++;
      $display("FAILED %s: expected period %0d, actual %0d",
               names[1], `GFX_H_WHOLE_LINE, $sampled(hs_since_fall));
    end

  a_vsync_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      !vs_rose || vs_low_len == `GFX_V_SYNC_PULSE * `GFX_H_WHOLE_LINE)
    else begin
      errs[2]++;
      $display("FAILED %s: expected pulse %0d, actual %0d",
               names[2], `GFX_V_SYNC_PULSE * `GFX_H_WHOLE_LINE, $sampled(vs_low_len));
    end

  a_vsync_period: assert property (@(posedge clk) disable iff (!arst_n)
      !(vs_fell && vs_fall_seen) || vs_since_fall == `GFX_V_WHOLE_FRAME * `GFX_H_WHOLE_LINE)
    else begin
      errs[2]++;
      $display("FAILED %s: expected period %0d, actual %0d",
               names[2], `GFX_V_WHOLE_FRAME * `GFX_H_WHOLE_LINE, $sampled(vs_since_fall));
    end

  a_pattern: assert property (@(posedge clk) disable iff (!arst_n)
      !m_vis || pin_color == exp_color)
    else begin
      errs[3]++;
      $display("FAILED %s: at (%0d,%0d) expected %03h, actual %03h", names[3],
               $sampled(mx), $sampled(my), $sampled(exp_color), $sampled(pin_color));
    end

  a_blanking: assert property (@(posedge clk) disable iff (!arst_n)
      !(synced && !m_vis) || pin_color == '0)
    else begin
      errs[4]++;
      $display("FAILED %s: at (%0d,%0d) expected 000, actual %03h", names[4],
               $sampled(mx), $sampled(my), $sampled(pin_color));
    end

  task automatic report_test(input int idx);
    if (checks[idx] == 0) begin
      errs[idx]++;
      $display("test %s never reached a check", names[idx]);
    end
    $display("test %-14s checks %0d, errors %0d", names[idx], checks[idx], errs[idx]);
  endtask

  initial begin
    int   wait_cnt;
    int   total_errs;
    int   total_checks;
    logic timed_out;
    names[0] = "reset_idle";
    names[1] = "hsync_timing";
    names[2] = "vsync_timing";
    names[3] = "visible_pattern";
    names[4] = "blanking";
    for (int i = 0; i < N_TESTS; i++) begin
      errs[i] = 0;
    end
    timed_out = 1'b0;
    clk       = 1'b0;
    arst_n    = 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    wait_cnt = 0;
    while (!synced && wait_cnt < 2000) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (!synced) begin
      $display("video did not start within 2000 cycles after reset release");
      timed_out = 1'b1;
    end else begin
      report_test(0);
      // two whole frames lie between the first and the third vsync fall
      wait_cnt = 0;
      while (vs_falls < 3 && wait_cnt < 1000) begin
        @(posedge clk);
        wait_cnt++;
      end
      if (vs_falls < 3) begin
        $display("two frames of video did not arrive within 1000 cycles");
        timed_out = 1'b1;
      end else begin
        for (int i = 0; i < `GFX_FB_DEPTH; i++) begin
          assert (hits[i] == 2) else begin
            errs[3]++;
            $display("FAILED %s: pixel (%0d,%0d) expected 2 checks, actual %0d",
                     names[3], i % `GFX_H_VISIBLE, i / `GFX_H_VISIBLE, hits[i]);
          end
        end
        for (int i = 1; i < N_TESTS; i++) begin
          report_test(i);
        end
      end
    end

    total_errs   = 0;
    total_checks = 0;
    for (int i = 0; i < N_TESTS; i++) begin
      total_errs   += errs[i];
      total_checks += checks[i];
    end
    $display("tests %0d, checks %0d, errors %0d", N_TESTS, total_checks, total_errs);
    if (timed_out || total_errs != 0) begin
      $display("Some tests failed");
    end else begin
      $display("All tests passed");
    end
    $finish;
  end

endmodule

// ==== verilog/gfx_demo.sv ====
`timescale 1ns/1ns

`include "gfx_macros.svh"

module gfx_demo import gfx_pkg::*; (
  input  logic                       clk,
  input  logic                       arst_n,
  output logic [`GFX_COLOR_BITS-1:0] vga_red,
  output logic [`GFX_COLOR_BITS-1:0] vga_grn,
  output logic [`GFX_COLOR_BITS-1:0] vga_blu,
  output logic                       vga_hsync,
  output logic                       vga_vsync
);

  // pattern to framebuffer
  gfx_pixel_t pix;
  logic       pix_valid;
  logic       pix_ready;
  logic       pix_last;

  // beam and read side
  vga_beam_t  beam;
  rgb_t       rd_color;
  logic       fb_filled;

  gfx_test_pattern pattern_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .pix_ready(pix_ready),
    .pix      (pix),
    .pix_valid(pix_valid),
    .pix_last (pix_last)
  );

  gfx_framebuffer fb_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .pix      (pix),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready),
    .pix_last (pix_last),
    .beam     (beam),
    .rd_color (rd_color),
    .fb_filled(fb_filled)
  );

  vga_timing timing_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .fb_filled(fb_filled),
    .beam     (beam)
  );

  vga_scanout scanout_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .beam     (beam),
    .rd_color (rd_color),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

endmodule

// ==== verilog/gfx_framebuffer.sv ====
`timescale 1ns/1ns

`include "gfx_macros.svh"

module gfx_framebuffer import gfx_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,

  // pattern side
  input  gfx_pixel_t pix,
  input  logic       pix_valid,
  output logic       pix_ready,
  input  logic       pix_last,

  // scanout side
  input  vga_beam_t  beam,
  output rgb_t       rd_color,
  output logic       fb_filled
);

  rgb_t                         mem [`GFX_FB_DEPTH];
  logic [`GFX_FB_ADDR_BITS-1:0] rd_addr;
  logic [`GFX_FB_ADDR_BITS-1:0] wr_addr;
  logic [`GFX_FB_ADDR_BITS-1:0] addr;
  logic                         wr_en;

  // address is y * 16 + x for both sides
  assign rd_addr = {beam.y[`GFX_Y_BITS-1:0], beam.x[`GFX_X_BITS-1:0]};
  assign wr_addr = {pix.y, pix.x};

  // the beam owns the port whenever it is in the visible area
  assign pix_ready = !beam.visible;
  assign wr_en     = pix_valid && pix_ready;
  assign addr      = beam.visible ? rd_addr : wr_addr;

  // single port with a registered read
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr] <= pix.color;
    end else if (beam.visible) begin
      rd_color <= mem[addr];
    end
  end

  // sticky once the last pixel of the first frame is in
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fb_filled <= 1'b0;
    end else if (wr_en && pix_last) begin
      fb_filled <= 1'b1;
    end
  end

endmodule

// ==== verilog/gfx_macros.svh ====
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// horizontal timing, in pixels
`define GFX_H_VISIBLE     16
`define GFX_H_FRONT_PORCH 2
`define GFX_H_SYNC_PULSE  3
`define GFX_H_BACK_PORCH  3
`define GFX_H_WHOLE_LINE  24

// vertical timing, in lines
`define GFX_V_VISIBLE     8
`define GFX_V_FRONT_PORCH 1
`define GFX_V_SYNC_PULSE  2
`define GFX_V_BACK_PORCH  1
`define GFX_V_WHOLE_FRAME 12

// sync pulse windows derived from the mode
`define GFX_H_SYNC_START (`GFX_H_VISIBLE + `GFX_H_FRONT_PORCH)
`define GFX_H_SYNC_END   (`GFX_H_SYNC_START + `GFX_H_SYNC_PULSE)
`define GFX_V_SYNC_START (`GFX_V_VISIBLE + `GFX_V_FRONT_PORCH)
`define GFX_V_SYNC_END   (`GFX_V_SYNC_START + `GFX_V_SYNC_PULSE)

// beam counter widths cover the whole line and frame
`define GFX_H_CNT_BITS $clog2(`GFX_H_WHOLE_LINE)
`define GFX_V_CNT_BITS $clog2(`GFX_V_WHOLE_FRAME)

// framebuffer coordinates and colour channel width
`define GFX_X_BITS     4
`define GFX_Y_BITS     3
`define GFX_COLOR_BITS 4

// one word per visible pixel
`define GFX_FB_DEPTH     128
`define GFX_FB_ADDR_BITS $clog2(`GFX_FB_DEPTH)

`endif

// ==== verilog/gfx_pkg.sv ====
`include "gfx_macros.svh"

package gfx_pkg;

  // 12-bit colour, 4 bits per channel
  typedef struct packed {
    logic [`GFX_COLOR_BITS-1:0] red;
    logic [`GFX_COLOR_BITS-1:0] grn;
    logic [`GFX_COLOR_BITS-1:0] blu;
  } rgb_t;

  // one pattern pixel with its framebuffer position
  typedef struct packed {
    logic [`GFX_X_BITS-1:0] x;
    logic [`GFX_Y_BITS-1:0] y;
    rgb_t                   color;
  } gfx_pixel_t;

  // beam position and flags, syncs are active low
  typedef struct packed {
    logic [`GFX_H_CNT_BITS-1:0] x;
    logic [`GFX_V_CNT_BITS-1:0] y;
    logic                       visible;
    logic                       hsync;
    logic                       vsync;
  } vga_beam_t;

endpackage

// ==== verilog/gfx_test_pattern.sv ====
`timescale 1ns/1ns

`include "gfx_macros.svh"

module gfx_test_pattern import gfx_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       pix_ready,
  output gfx_pixel_t pix,
  output logic       pix_valid,
  output logic       pix_last
);

  logic [`GFX_X_BITS-1:0]     x_cnt;
  logic [`GFX_Y_BITS-1:0]     y_cnt;
  logic [`GFX_COLOR_BITS-1:0] x_ext;
  logic [`GFX_COLOR_BITS-1:0] y_ext;
  logic                       xfer;

  assign xfer = pix_valid && pix_ready;

  // valid comes up one cycle after reset and then stays up
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= 1'b1;
    end
  end

  // raster order, wrapping at the end of the frame
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (xfer) begin
      if (x_cnt == `GFX_H_VISIBLE - 1) begin
        x_cnt <= '0;
        if (y_cnt == `GFX_V_VISIBLE - 1) begin
          y_cnt <= '0;
        end else begin
          y_cnt <= y_cnt + 1'b1;
        end
      end else begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  assign pix_last = (x_cnt == `GFX_H_VISIBLE - 1) && (y_cnt == `GFX_V_VISIBLE - 1);

  // zero extension to the channel width
  assign x_ext = x_cnt;
  assign y_ext = y_cnt;

  always_comb begin
    pix.x         = x_cnt;
    pix.y         = y_cnt;
    pix.color.red = x_ext;
    pix.color.grn = y_ext;
    pix.color.blu = x_ext ^ y_ext;
  end

endmodule

// ==== verilog/vga_scanout.sv ====
`timescale 1ns/1ns

`include "gfx_macros.svh"

module vga_scanout import gfx_pkg::*; (
  input  logic                       clk,
  input  logic                       arst_n,
  input  vga_beam_t                  beam,
  input  rgb_t                       rd_color,
  output logic [`GFX_COLOR_BITS-1:0] vga_red,
  output logic [`GFX_COLOR_BITS-1:0] vga_grn,
  output logic [`GFX_COLOR_BITS-1:0] vga_blu,
  output logic                       vga_hsync,
  output logic                       vga_vsync
);

  logic visible_d;
  logic hsync_d;
  logic vsync_d;
  rgb_t color_q;

  // first stage lines the flags up with the memory read data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      visible_d <= 1'b0;
      hsync_d   <= 1'b1;
      vsync_d   <= 1'b1;
    end else begin
      visible_d <= beam.visible;
      hsync_d   <= beam.hsync;
      vsync_d   <= beam.vsync;
    end
  end

  // second stage drives the pins, black during blanking
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      color_q   <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end else begin
      color_q   <= visible_d ? rd_color : '0;
      vga_hsync <= hsync_d;
      vga_vsync <= vsync_d;
    end
  end

  assign vga_red = color_q.red;
  assign vga_grn = color_q.grn;
  assign vga_blu = color_q.blu;

endmodule

// ==== verilog/vga_timing.sv ====
`timescale 1ns/1ns

`include "gfx_macros.svh"

module vga_timing import gfx_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      fb_filled,
  output vga_beam_t beam
);

  logic [`GFX_H_CNT_BITS-1:0] h_cnt;
  logic [`GFX_V_CNT_BITS-1:0] v_cnt;
  logic                       h_end;
  logic                       v_end;

  assign h_end = (h_cnt == `GFX_H_WHOLE_LINE - 1);
  assign v_end = (v_cnt == `GFX_V_WHOLE_FRAME - 1);

  // parked at the origin until the first frame is in memory
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (fb_filled) begin
      if (h_end) begin
        h_cnt <= '0;
        if (v_end) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    beam.x = h_cnt;
    beam.y = v_cnt;

    // no visible pixels while parked, so pattern writes can proceed
    beam.visible = fb_filled
                && (h_cnt < `GFX_H_VISIBLE)
                && (v_cnt < `GFX_V_VISIBLE);

    beam.hsync = !((h_cnt >= `GFX_H_SYNC_START) && (h_cnt < `GFX_H_SYNC_END));

    // vsync covers whole lines
    beam.vsync = !((v_cnt >= `GFX_V_SYNC_START) && (v_cnt < `GFX_V_SYNC_END));
  end

endmodule
